// ==== filelist.f ====
src/fir_pkg.sv
src/tap_sequencer.sv
src/sample_delay_line.sv
src/vedic_mult.sv
src/mac_unit.sv
src/fir_serial_top.sv
test/fir_serial_sva.sv
test/fir_serial_tb.sv

// ==== test/fir_stimulus.txt ====
# sample (Q1.15, decimal)  expected filter_out at the matching out_valid (Q2.31, decimal)
# one line per frame, line j expects y[j-2]
16384 0
0 0
0 -143736832
0 -89948160
0 217497600
0 436338688
0 436338688
0 217497600
0 -89948160
0 -143736832
-32768 0
-32768 0
-32768 287473664
-32768 467369984
-32768 32374784
-32768 -840302592
-32768 -1712979968
-32768 -2147975168
-32768 -1968078848
-32768 -1680605184
0 -1680605184
0 -1680605184
0 -1968078848
0 -2147975168
0 -1712979968
0 -840302592
0 32374784
32767 467369984
-32767 287473664
32767 -287464891
-32767 107574061
32767 327407864
-32767 545242880
32767 327407864
-32767 107574061
32767 -287464891
-32767 0
0 0
0 0
0 287464891
0 -107574061
0 -327407864
0 -545242880
0 -327407864
29919 -107574061
-9973 287464891
19946 -262479387
-29919 -76762181
0 276940237
9973 817387080
-19946 960240332
29919 178107807
9973 -442013333
-9973 -760331547
-29919 -670115789
19946 153584200
0 1110094630
0 599746301
0 -87493129
0 -654498071
0 -715223668
0 101285788
0 516531589
0 152975847
0 -174986258
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0
0 0

// ==== test/fir_serial_tb.sv ====
`timescale 1ns/1ps

module fir_serial_tb import fir_pkg::*; ();

  localparam int    CLK_PERIOD  = 8;
  localparam int    RESET_CYCLES = 8;
  localparam int    MAX_GAP     = 5;
  localparam int    GAP_START   = 27;  // frames from here on run with enable gaps
  localparam string STIM_FILE   = "test/fir_stimulus.txt";

  logic                       clk;
  logic                       reset;
  logic                       clk_enable;
  logic signed [SAMPLE_W-1:0] filter_in;
  logic signed [ACC_W-1:0]    filter_out;
  logic                       out_valid;

  int     samples[$];
  longint expected[$];
  int     errors;
  int     checks;
  int     sva_fails;
  int     frame_edges;  // enabled edges since the last out_valid
  int     pulses;
  bit     gaps_on;
  bit     stim_loaded;
  int     seed;

  fir_serial_top i_fir_serial_top (
    .clk        (clk),
    .reset      (reset),
    .clk_enable (clk_enable),
    .filter_in  (filter_in),
    .filter_out (filter_out),
    .out_valid  (out_valid)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////////////////////////
  // helpers
  ////////////////////////////////////////

  task automatic check_value(input string name, input longint actual, input longint exp_val);
    checks++;
    if (actual !== exp_val) begin
      errors++;
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual, exp_val);
    end
  endtask

  task automatic load_stimulus();
    int     fd;
    int     n;
    int     s;
    longint e;
    string  line;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while ($fgets(line, fd)) begin
        if (line.len() > 1 && line[0] != "#") begin  // skip column notes
          n = $sscanf(line, "%d %d", s, e);
          if (n == 2) begin
            samples.push_back(s);
            expected.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // enable gaps
  ////////////////////////////////////////

  always begin
    int gap;
    @(posedge clk);
    if (gaps_on && ($urandom % 4) == 0) begin
      gap = 1 + ($urandom % MAX_GAP);
      clk_enable <= 1'b0;
      repeat (gap) @(posedge clk);
      clk_enable <= 1'b1;
    end
  end

  // clk_enable at a negedge is what the next rising edge sees
  always @(negedge clk) begin
    if (!reset) begin
      if (out_valid) begin
        if (pulses > 0) begin
          check_value("out_valid spacing", frame_edges, TAPS);
        end
        pulses++;
        frame_edges = 0;
      end
      if (clk_enable) begin
        frame_edges++;
      end
    end
  end

  // worst case every enabled cycle trails a full gap
  initial begin
    longint limit_ns;
    wait (stim_loaded);
    limit_ns = (longint'(samples.size()) * TAPS * (MAX_GAP + 1) + 100) * CLK_PERIOD;
    #(limit_ns);
    $display("ERROR: timeout, out_valid stopped arriving after %0d checks", checks);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Test FAILED");
    $finish;
  end

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    clk_enable  = 1'b0;
    filter_in   = '0;
    errors      = 0;
    checks      = 0;
    sva_fails   = 0;
    frame_edges = 0;
    pulses      = 0;
    gaps_on     = 1'b0;
    seed        = 32'hd140;
    void'($urandom(seed));

    load_stimulus();
    stim_loaded = 1'b1;

    if (samples.size() == 0) begin
      errors++;
      $display("ERROR: no stimulus lines could be read from %s", STIM_FILE);
    end else begin
      @(posedge clk);
      filter_in <= samples[0];  // sample 0 waits during reset
      repeat (RESET_CYCLES - 1) @(posedge clk);
      reset <= 1'b0;

      // no enabled edge yet
      @(negedge clk);
      check_value("filter_out", filter_out, 0);
      check_value("out_valid", out_valid, 0);

      @(posedge clk);
      clk_enable <= 1'b1;

      for (int j = 0; j < samples.size(); j++) begin
        gaps_on = (j >= GAP_START);
        @(negedge clk);
        while (!out_valid) @(negedge clk);
        check_value("filter_out", filter_out, expected[j]);
        if (j + 1 < samples.size()) begin
          @(posedge clk);
          filter_in <= samples[j+1];
        end
      end
    end

    sva_fails = i_fir_serial_top.i_fir_serial_sva.assert_failures;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, sva_fails);
    if (errors == 0 && sva_fails == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== test/fir_serial_sva.sv ====
`timescale 1ns/1ps

module fir_serial_sva import fir_pkg::*; (
  input logic                    clk,
  input logic                    reset,
  input logic                    clk_enable,
  input logic signed [ACC_W-1:0] filter_out,
  input logic                    out_valid
);

  int assert_failures = 0;

  ////////////////////////////////////////
  // output strobe
  ////////////////////////////////////////

  a_valid_single: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |=> !out_valid
  ) else begin
    assert_failures++;
    $error("out_valid stayed high for two cycles");
  end

  // filter_out and out_valid update on the same load edge
  a_out_on_load: assert property (
    @(posedge clk) disable iff (reset)
    !$stable(filter_out) |-> $rose(out_valid)
  ) else begin
    assert_failures++;
    $error("filter_out changed outside a load edge");
  end

  a_valid_enabled: assert property (
    @(posedge clk) disable iff (reset)
    $rose(out_valid) |-> $past(clk_enable)
  ) else begin
    assert_failures++;
    $error("out_valid rose after a disabled edge");
  end

endmodule

bind fir_serial_top fir_serial_sva i_fir_serial_sva (
  .clk        (clk),
  .reset      (reset),
  .clk_enable (clk_enable),
  .filter_out (filter_out),
  .out_valid  (out_valid)
);

// ==== src/fir_serial_top.sv ====
`timescale 1ns/1ps

module fir_serial_top import fir_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clk_enable,
  input  logic signed [SAMPLE_W-1:0] filter_in,
  output logic signed [ACC_W-1:0]    filter_out,
  output logic                       out_valid
);

  logic [COUNT_W-1:0]         tap_index;
  logic                       load_phase;   // tap 7, enabled
  logic                       first_phase;  // tap 0, enabled
  logic signed [SAMPLE_W-1:0] tap_sample;

  ////////////////////////////////////////
  // sequencer -> delay line -> mac
  ////////////////////////////////////////

  tap_sequencer i_tap_sequencer (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .tap_index   (tap_index),
    .load_phase  (load_phase),
    .first_phase (first_phase)
  );

  sample_delay_line i_sample_delay_line (
    .clk        (clk),
    .reset      (reset),
    .load_phase (load_phase),
    .tap_index  (tap_index),
    .filter_in  (filter_in),
    .tap_sample (tap_sample)
  );

  mac_unit i_mac_unit (
    .clk         (clk),
    .reset       (reset),
    .clk_enable  (clk_enable),
    .tap_index   (tap_index),
    .first_phase (first_phase),
    .load_phase  (load_phase),
    .tap_sample  (tap_sample),
    .filter_out  (filter_out),
    .out_valid   (out_valid)
  );

endmodule

// ==== src/mac_unit.sv ====
`timescale 1ns/1ps

module mac_unit import fir_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       clk_enable,
  input  logic [COUNT_W-1:0]         tap_index,
  input  logic                       first_phase,
  input  logic                       load_phase,
  input  logic signed [SAMPLE_W-1:0] tap_sample,
  output logic signed [ACC_W-1:0]    filter_out,
  output logic                       out_valid
);

  localparam int FULL_W = SAMPLE_W + COEFF_W;

  logic signed [COEFF_W-1:0] coeff;
  logic [COEFF_W-1:0]        coeff_mag;
  logic [SAMPLE_W-1:0]       sample_mag;
  logic                      prod_neg;
  logic [FULL_W-1:0]         mag_prod;
  logic [FULL_W-1:0]         signed_prod;
  logic signed [PROD_W-1:0]  product;
  logic signed [ACC_W-1:0]   prod_ext;
  logic signed [ACC_W-1:0]   acc_q;
  logic signed [ACC_W-1:0]   final_q;

  ////////////////////////////////////////
  // signed multiply
  ////////////////////////////////////////

  assign coeff = COEFFS[tap_index];

  // -32768 maps to 16'h8000, still a valid magnitude
  assign coeff_mag  = coeff[COEFF_W-1] ? (~coeff + 1'b1) : coeff;
  assign sample_mag = tap_sample[SAMPLE_W-1] ? (~tap_sample + 1'b1) : tap_sample;
  assign prod_neg   = coeff[COEFF_W-1] ^ tap_sample[SAMPLE_W-1];

  vedic_mult #(.WIDTH(SAMPLE_W)) i_vedic_mult (
    .a       (sample_mag),
    .b       (coeff_mag),
    .product (mag_prod)
  );

  assign signed_prod = prod_neg ? (~mag_prod + 1'b1) : mag_prod;
  assign product     = signed_prod[PROD_W-1:0];  // drop redundant sign bit
  assign prod_ext    = {{(ACC_W - PROD_W){product[PROD_W-1]}}, product};

  ////////////////////////////////////////
  // accumulate and output
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      acc_q <= '0;
    end else if (clk_enable) begin
      if (first_phase) begin
        acc_q <= prod_ext;  // restart on tap 0
      end else begin
        acc_q <= acc_q + prod_ext;
      end
    end
  end

  // acc_q holds all eight taps on the tap 0 edge
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      final_q <= '0;
    end else if (first_phase) begin
      final_q <= acc_q;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      filter_out <= '0;
      out_valid  <= 1'b0;
    end else begin
      out_valid <= load_phase;  // one clock, load_phase carries the enable
      if (load_phase) begin
        filter_out <= final_q;
      end
    end
  end

endmodule

// ==== src/vedic_mult.sv ====
`timescale 1ns/1ps

module vedic_mult #(
  parameter int WIDTH = 16
) (
  input  logic [WIDTH-1:0]   a,
  input  logic [WIDTH-1:0]   b,
  output logic [2*WIDTH-1:0] product
);

  generate
    if (WIDTH == 2) begin : g_leaf

      ////////////////////////////////////////
      // 2x2 cell
      ////////////////////////////////////////

      logic pp_lo_hi;  // a[1]*b[0]
      logic pp_hi_lo;  // a[0]*b[1]
      logic pp_hi_hi;
      logic carry_mid;

      assign pp_lo_hi  = a[1] & b[0];
      assign pp_hi_lo  = a[0] & b[1];
      assign pp_hi_hi  = a[1] & b[1];
      assign carry_mid = pp_lo_hi & pp_hi_lo;

      assign product[0] = a[0] & b[0];        // vertical
      assign product[1] = pp_lo_hi ^ pp_hi_lo; // crosswise
      assign product[2] = pp_hi_hi ^ carry_mid;
      assign product[3] = pp_hi_hi & carry_mid;

    end else begin : g_split

      localparam int H = WIDTH / 2;

      logic [2*H-1:0] q_ll;  // a_lo * b_lo
      logic [2*H-1:0] q_hl;  // a_hi * b_lo
      logic [2*H-1:0] q_lh;  // a_lo * b_hi
      logic [2*H-1:0] q_hh;  // a_hi * b_hi
      logic [2*H-1:0] mid_sum;
      logic [3*H-1:0] outer_sum;
      logic [3*H-1:0] upper_sum;

      vedic_mult #(.WIDTH(H)) i_ll (.a(a[H-1:0]),     .b(b[H-1:0]),     .product(q_ll));
      vedic_mult #(.WIDTH(H)) i_hl (.a(a[WIDTH-1:H]), .b(b[H-1:0]),     .product(q_hl));
      vedic_mult #(.WIDTH(H)) i_lh (.a(a[H-1:0]),     .b(b[WIDTH-1:H]), .product(q_lh));
      vedic_mult #(.WIDTH(H)) i_hh (.a(a[WIDTH-1:H]), .b(b[WIDTH-1:H]), .product(q_hh));

      // upper half of q_ll folds into the first crosswise term
      assign mid_sum   = {{H{1'b0}}, q_ll[2*H-1:H]} + q_hl;
      assign outer_sum = {{H{1'b0}}, q_lh} + {q_hh, {H{1'b0}}};
      assign upper_sum = {{H{1'b0}}, mid_sum} + outer_sum;

      assign product[H-1:0]       = q_ll[H-1:0];  // vertical low bits pass straight
      assign product[2*WIDTH-1:H] = upper_sum;

    end
  endgenerate

endmodule

// ==== src/sample_delay_line.sv ====
`timescale 1ns/1ps

module sample_delay_line import fir_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       load_phase,
  input  logic [COUNT_W-1:0]         tap_index,
  input  logic signed [SAMPLE_W-1:0] filter_in,
  output logic signed [SAMPLE_W-1:0] tap_sample
);

  logic signed [SAMPLE_W-1:0] delay_q [TAPS];  // [0] newest

  ////////////////////////////////////////
  // shift register
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < TAPS; i++) begin
        delay_q[i] <= '0;
      end
    end else if (load_phase) begin
      delay_q[0] <= filter_in;  // capture new sample
      for (int i = 1; i < TAPS; i++) begin
        delay_q[i] <= delay_q[i-1];
      end
    end
  end

  ////////////////////////////////////////
  // tap select
  ////////////////////////////////////////

  // the shift happens on the load edge itself, so during tap 7
  // the oldest sample is still in place when it is read
  assign tap_sample = delay_q[tap_index];

endmodule

// ==== src/tap_sequencer.sv ====
`timescale 1ns/1ps

module tap_sequencer import fir_pkg::*; (
  input  logic               clk,
  input  logic               reset,
  input  logic               clk_enable,
  output logic [COUNT_W-1:0] tap_index,
  output logic               load_phase,
  output logic               first_phase
);

  localparam logic [COUNT_W-1:0] LAST_TAP  = COUNT_W'(TAPS - 1);
  localparam logic [COUNT_W-1:0] FIRST_TAP = '0;

  ////////////////////////////////////////
  // tap counter
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tap_index <= LAST_TAP;  // first enabled edge is a load
    end else if (clk_enable) begin
      if (tap_index == LAST_TAP) begin
        tap_index <= FIRST_TAP;
      end else begin
        tap_index <= tap_index + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // frame strobes
  ////////////////////////////////////////

  // both carry the enable, downstream never tests it again
  assign load_phase  = clk_enable && (tap_index == LAST_TAP);
  assign first_phase = clk_enable && (tap_index == FIRST_TAP);

endmodule

// ==== src/fir_pkg.sv ====
package fir_pkg;

  ////////////////////////////////////////
  // frame and word sizes
  ////////////////////////////////////////

  localparam int TAPS     = 8;   // taps, also enabled cycles per frame
  localparam int COUNT_W  = 3;   // tap index width

  localparam int SAMPLE_W = 16;  // Q1.15 input
  localparam int COEFF_W  = 16;  // Q0.16 coefficients

  // full product is 32 bits, top bit only repeats the sign
  localparam int PROD_W   = 31;  // Q0.31

  // eight 31-bit products always fit here
  localparam int ACC_W    = 33;  // Q2.31

  ////////////////////////////////////////
  // coefficient table
  ////////////////////////////////////////

  // symmetric lowpass set, tap 0 first
  localparam logic signed [COEFF_W-1:0] COEFFS [TAPS] = '{
    -16'sd8773,
    -16'sd5490,
    16'sd13275,
    16'sd26632,  // centre pair
    16'sd26632,
    16'sd13275,
    -16'sd5490,
    -16'sd8773
  };

endpackage
